// ==== qsnd_pkg.sv ====
//////////////////////////////
// shared types for the sound board glue
// sound bus cycle struct, DSP output struct
// region and mailbox index enums
// address width constants
//////////////////////////////

package qsnd_pkg;

    localparam int rom_aw  = 19; // program ROM, 512 kB
    localparam int qsnd_aw = 23; // sample ROM, up to 8 MB
    localparam int ram_aw  = 13; // work RAM, 8 kB

    // one sound bus cycle, CPU or main CPU side
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  dout;
        logic        mreq_n;
        logic        rd_n;
        logic        wr_n;
        logic        m1_n;
        logic        iorq_n;
    } cpu_bus_t;

    // decoded region of the current memory cycle
    typedef enum logic [2:0] {
        rgn_none,
        rgn_rom,
        rgn_bank_rom,
        rgn_ram,
        rgn_mbox_wr,
        rgn_bank_wr,
        rgn_status
    } region_e;

    // register index inside the 0xd000 page, address bits 2:0
    typedef enum logic [2:0] {
        mbox_data_hi = 3'd0,
        mbox_data_lo = 3'd1,
        mbox_addr    = 3'd2,
        mbox_bank    = 3'd3,
        mbox_status  = 3'd7
    } mbox_e;

    // what the DSP core drives back to the board
    typedef struct packed {
        logic [15:0] pbus_out;
        logic [15:0] ab;
        logic [15:0] ser_out;
        logic        pods_n;
        logic        pids_n;
        logic        sadd;
        logic        psel;
        logic        cen_cko;
        logic        iack;
    } dsp_out_t;

endpackage

// ==== qsnd_bus_decode.sv ====
//////////////////////////////
// sound bus decoder
// bus owner mux (sound CPU or main CPU)
// registered region decode, program ROM address
// read data mux and ROM wait flag
//////////////////////////////
`timescale 1ns/1ns

module qsnd_bus_decode import qsnd_pkg::*; (
    input  logic              clk48,
    input  logic              rst,
    input  cpu_bus_t          cpu,
    input  logic [23:1]       main_addr,
    input  logic [7:0]        main_dout,
    input  logic              main_ldswn,
    input  logic              main_busn,
    input  logic [7:0]        rom_data,
    input  logic              rom_ok,
    input  logic [7:0]        ram_q,
    input  logic [3:0]        bank,
    input  logic              dsp_rdy_n,
    output logic [rom_aw-1:0] rom_addr,
    output logic              rom_cs,
    output logic [ram_aw-1:0] ram_addr,
    output logic              ram_we,
    output logic [7:0]        ram_din,
    output logic              mbox_wr,
    output mbox_e             mbox_idx,
    output logic              bank_wr,
    output logic [7:0]        wr_data,
    output logic [7:0]        cpu_din,
    output logic [7:0]        main_din,
    output logic              rom_wait
);

    cpu_bus_t bus;      // bus as seen after the ownership mux
    region_e  rgn_d;
    region_e  rgn_q;
    mbox_e    idx_d;
    logic     rom_ok_q;

    // main CPU drives the bus once the grant is through
    always_comb begin
        bus = cpu;
        if (!main_busn) begin
            bus.addr   = main_addr[16:1];
            bus.dout   = main_dout;
            bus.wr_n   = main_ldswn;
            bus.rd_n   = ~main_ldswn;
            bus.mreq_n = 1'b0; // every main access is a memory cycle
        end
    end

    assign idx_d = mbox_e'(bus.addr[2:0]);

    always_comb begin
        rgn_d = rgn_none;
        if (!bus.mreq_n) begin
            if (!bus.addr[15])
                rgn_d = rgn_rom;
            else if (bus.addr[15:14] == 2'b10)
                rgn_d = rgn_bank_rom;
            else if (bus.addr[15:12] == 4'hc || bus.addr[15:12] == 4'hf)
                rgn_d = rgn_ram;
            else if (bus.addr[15:12] == 4'hd) begin
                if (!bus.wr_n && idx_d <= mbox_addr)
                    rgn_d = rgn_mbox_wr;
                else if (!bus.wr_n && idx_d == mbox_bank)
                    rgn_d = rgn_bank_wr;
                else if (!bus.rd_n && idx_d == mbox_status)
                    rgn_d = rgn_status;
            end
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            rgn_q    <= rgn_none;
            rom_ok_q <= 1'b0;
            rom_addr <= '0;
        end else begin
            rgn_q    <= rgn_d;
            rom_ok_q <= rom_ok;
            if (!bus.mreq_n)  // banked window starts at 0x8000 in the ROM
                rom_addr <= bus.addr[15] ? ({1'b0, bank, bus.addr[13:0]} + 19'h8000)
                                         : {4'd0, bus.addr[14:0]};
        end
    end

    // write payload follows the strobe by one clock
    always_ff @(posedge clk48) begin
        mbox_idx <= idx_d;
        wr_data  <= bus.dout;
        main_din <= cpu_din;
    end

    assign rom_cs   = (rgn_q == rgn_rom) || (rgn_q == rgn_bank_rom);
    assign rom_wait = rom_cs & ~rom_ok_q;
    assign mbox_wr  = (rgn_q == rgn_mbox_wr);
    assign bank_wr  = (rgn_q == rgn_bank_wr);
    assign ram_addr = bus.addr[ram_aw-1:0];
    assign ram_din  = bus.dout;
    assign ram_we   = (rgn_q == rgn_ram) && !bus.wr_n;

    always_comb begin
        case (rgn_q)
            rgn_rom, rgn_bank_rom: cpu_din = rom_data; // no opcode decryption
            rgn_ram:               cpu_din = ram_q;
            rgn_status:            cpu_din = {dsp_rdy_n, 3'b111, bank};
            default:               cpu_din = 8'hff;
        endcase
    end

endmodule

// ==== qsnd_regs.sv ====
//////////////////////////////
// sound board registers
// ROM bank and DSP reset
// 24-bit CPU to DSP mailbox
// DSP interrupt and data select sequence
//////////////////////////////
`timescale 1ns/1ns

module qsnd_regs import qsnd_pkg::*; (
    input  logic        clk48,
    input  logic        rst,
    input  logic        mbox_wr,
    input  mbox_e       mbox_idx,
    input  logic        bank_wr,
    input  logic [7:0]  wr_data,
    input  logic        dsp_pids_n,
    input  logic        dsp_iack,
    output logic [3:0]  bank,
    output logic        dsp_rst,
    output logic        dsp_irq,
    output logic        dsp_rdy_n,
    output logic [15:0] dsp_pbus_in
);

    logic [23:0] mbox;        // {address, data word}
    logic [1:0]  data_sel;
    logic        last_pids_n;
    logic        pids_rise;

    assign pids_rise = dsp_pids_n & ~last_pids_n;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            bank    <= 4'd0;
            dsp_rst <= 1'b1; // DSP held until the CPU releases it
        end else if (bank_wr) begin
            bank    <= wr_data[3:0];
            dsp_rst <= ~wr_data[7];
        end
    end

    always_ff @(posedge clk48) begin
        if (mbox_wr) begin
            case (mbox_idx)
                mbox_data_hi: mbox[15:8]  <= wr_data;
                mbox_data_lo: mbox[7:0]   <= wr_data;
                mbox_addr:    mbox[23:16] <= wr_data;
                default: ;
            endcase
        end
    end

    // writing the address byte kicks off the DSP transfer
    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            dsp_irq     <= 1'b0;
            data_sel    <= 2'b00;
            last_pids_n <= 1'b1;
        end else begin
            last_pids_n <= dsp_pids_n;
            if (mbox_wr && mbox_idx == mbox_addr) begin
                dsp_irq  <= 1'b1;
                data_sel <= 2'b11;
            end else if (pids_rise) begin
                dsp_irq  <= 1'b0; // first read done
                data_sel <= data_sel >> 1;
            end
        end
    end

    assign dsp_rdy_n   = ~(dsp_irq | dsp_iack);
    assign dsp_pbus_in = data_sel[1] ? {8'd0, mbox[23:16]} : mbox[15:0];

endmodule

// ==== qsnd_buslock.sv ====
//////////////////////////////
// main CPU bus request and grant
// grant synchronised on cen8
//////////////////////////////
`timescale 1ns/1ns

module qsnd_buslock (
    input  logic clk48,
    input  logic rst,
    input  logic cen8,
    input  logic main_buse_n,
    input  logic cpu_busak_n,
    input  logic rom_wait,
    output logic cpu_busrq_n,
    output logic main_busn,
    output logic main_busakn
);

    logic [1:0] sync;   // grant pipeline, active low

    assign cpu_busrq_n = main_buse_n;   // request goes straight to the CPU
    assign main_busn   = sync[1];

    // held off while a ROM cycle is still waiting for data
    assign main_busakn = sync[1] | main_buse_n | rom_wait;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst)
            sync <= 2'b11;
        else if (main_buse_n)
            sync <= 2'b11;  // request dropped, back to idle
        else if (cen8)
            sync <= {sync[0], cpu_busak_n};
    end

endmodule

// ==== qsnd_cpu_timing.sv ====
//////////////////////////////
// sound CPU timing
// periodic interrupt with acknowledge
// one wait slot on fetches at 0x4000 and up
//////////////////////////////
`timescale 1ns/1ns

module qsnd_cpu_timing #(
    parameter int int_period = 32000
) (
    input  logic       clk48,
    input  logic       rst,
    input  logic       cen8,
    input  logic       m1_n,
    input  logic       iorq_n,
    input  logic [3:0] fetch_page,
    output logic       int_n,
    output logic       cpu_cen
);

    localparam int cw = $clog2(int_period + 1);

    logic [cw-1:0] cnt;
    logic          cnt_over;
    logic          idle;    // swallows one cen8 tick
    logic          done;    // one slot per fetch

    assign cnt_over = (cnt == cw'(int_period - 1));
    assign cpu_cen  = cen8 & ~idle;

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            int_n <= 1'b1;
        end else if (cen8) begin
            cnt <= cnt_over ? '0 : cnt + 1'b1;
            if (!m1_n && !iorq_n)
                int_n <= 1'b1;  // interrupt acknowledge cycle
            else if (cnt_over)
                int_n <= 1'b0;
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            idle <= 1'b0;
            done <= 1'b0;
        end else if (cen8) begin
            if (idle)
                idle <= 1'b0;
            else if (!m1_n && fetch_page >= 4'h4 && !done) begin
                idle <= 1'b1;
                done <= 1'b1;
            end
            if (m1_n)
                done <= 1'b0;   // fetch over, rearm
        end
    end

endmodule

// ==== qsnd_audio_latch.sv ====
//////////////////////////////
// DSP audio capture
// serial word latch into left and right
// sample strobe, sample ROM address
//////////////////////////////
`timescale 1ns/1ns

module qsnd_audio_latch import qsnd_pkg::*; (
    input  logic               clk48,
    input  logic               rst,
    input  dsp_out_t           dsp,
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample,
    output logic [qsnd_aw-1:0] qsnd_addr
);

    logic signed [15:0] word_l;
    logic signed [15:0] word_r;
    logic               last_sadd;
    logic               last_psel;
    logic               last_pods_n;
    logic               sadd_fall;
    logic               psel_rise;

    assign sadd_fall = last_sadd & ~dsp.sadd;
    assign psel_rise = dsp.psel & ~last_psel;

    // serial port bypassed, word taken in parallel
    always_ff @(posedge clk48) begin
        if (sadd_fall) begin
            if (dsp.psel)
                word_r <= dsp.ser_out;
            else
                word_l <= dsp.ser_out;
        end
    end

    always_ff @(posedge clk48 or posedge rst) begin
        if (rst) begin
            last_sadd   <= 1'b0;
            last_psel   <= 1'b0;
            last_pods_n <= 1'b1;
            left        <= '0;
            right       <= '0;
            sample      <= 1'b0;
            qsnd_addr   <= '0;
        end else begin
            last_sadd   <= dsp.sadd;
            last_psel   <= dsp.psel;
            last_pods_n <= dsp.pods_n;
            sample      <= 1'b0;
            if (psel_rise) begin
                left   <= word_l <<< 2;    // gain of 4
                right  <= word_r <<< 2;
                sample <= 1'b1;
            end
            if (dsp.pods_n && !last_pods_n)
                qsnd_addr[15:0] <= dsp.pbus_out;
            // high bits come from the external address bus
            if (dsp.ab[15] && dsp.cen_cko)
                qsnd_addr[qsnd_aw-1:16] <= dsp.ab[6:0];
        end
    end

endmodule

// ==== qsnd_sound.sv ====
//////////////////////////////
// QSound sound board glue, top level
// bus decode, registers, bus lock
// CPU timing and audio capture
//////////////////////////////
`timescale 1ns/1ns

module qsnd_sound import qsnd_pkg::*; #(
    parameter int int_period = 32000
) (
    input  logic               clk48,
    input  logic               rst,
    input  logic               cen8,
    // sound CPU
    input  cpu_bus_t           cpu,
    input  logic               cpu_busak_n,
    output logic [7:0]         cpu_din,
    output logic               cpu_busrq_n,
    output logic               cpu_cen,
    output logic               int_n,
    // main CPU
    input  logic [23:1]        main_addr,
    input  logic [7:0]         main_dout,
    input  logic               main_ldswn,
    input  logic               main_buse_n,
    output logic [7:0]         main_din,
    output logic               main_busakn,
    // program ROM and work RAM
    input  logic [7:0]         rom_data,
    input  logic               rom_ok,
    output logic [rom_aw-1:0]  rom_addr,
    output logic               rom_cs,
    input  logic [7:0]         ram_q,
    output logic [ram_aw-1:0]  ram_addr,
    output logic               ram_we,
    output logic [7:0]         ram_din,
    // DSP
    input  dsp_out_t           dsp,
    output logic               dsp_rst,
    output logic               dsp_irq,
    output logic [15:0]        dsp_pbus_in,
    // audio
    output logic signed [15:0] left,
    output logic signed [15:0] right,
    output logic               sample,
    output logic [qsnd_aw-1:0] qsnd_addr
);

    logic [3:0] bank;
    logic       dsp_rdy_n;
    logic       mbox_wr;
    mbox_e      mbox_idx;
    logic       bank_wr;
    logic [7:0] wr_data;
    logic       main_busn;
    logic       rom_wait;

    qsnd_bus_decode u_decode (
        .clk48, .rst, .cpu, .main_addr, .main_dout, .main_ldswn, .main_busn,
        .rom_data, .rom_ok, .ram_q, .bank, .dsp_rdy_n,
        .rom_addr, .rom_cs, .ram_addr, .ram_we, .ram_din,
        .mbox_wr, .mbox_idx, .bank_wr, .wr_data, .cpu_din, .main_din, .rom_wait
    );

    qsnd_regs u_regs (
        .clk48, .rst, .mbox_wr, .mbox_idx, .bank_wr, .wr_data,
        .dsp_pids_n (dsp.pids_n),
        .dsp_iack   (dsp.iack),
        .bank, .dsp_rst, .dsp_irq, .dsp_rdy_n, .dsp_pbus_in
    );

    qsnd_buslock u_buslock (
        .clk48, .rst, .cen8, .main_buse_n, .cpu_busak_n, .rom_wait,
        .cpu_busrq_n, .main_busn, .main_busakn
    );

    qsnd_cpu_timing #(.int_period(int_period)) u_timing (
        .clk48, .rst, .cen8,
        .m1_n       (cpu.m1_n),
        .iorq_n     (cpu.iorq_n),
        .fetch_page (cpu.addr[15:12]),  // fetches come from the sound CPU only
        .int_n, .cpu_cen
    );

    qsnd_audio_latch u_audio (
        .clk48, .rst, .dsp, .left, .right, .sample, .qsnd_addr
    );

endmodule

// ==== qsnd_sva.sv ====
//////////////////////////////
// assertions on the sound board top
// sample strobe width, RAM write region
// bus grant only while requested
//////////////////////////////
`timescale 1ns/1ns

module qsnd_sva import qsnd_pkg::*; (
    input logic        clk48,
    input logic        rst,
    input cpu_bus_t    cpu,
    input logic [23:1] main_addr,
    input logic        main_buse_n,
    input logic        main_busakn,
    input logic        ram_we,
    input logic        sample
);

    logic cpu_in_ram;
    logic main_in_ram;

    assign cpu_in_ram  = (cpu.addr[15:12] == 4'hc) || (cpu.addr[15:12] == 4'hf);
    assign main_in_ram = !main_buse_n
                         && ((main_addr[16:13] == 4'hc) || (main_addr[16:13] == 4'hf));

    sample_one_clock: assert property (@(posedge clk48) disable iff (rst)
        sample |=> !sample)
        else $error("sample strobe high for more than one clock");

    // either bus owner must point into 0xc000 or 0xf000
    ram_we_region: assert property (@(posedge clk48) disable iff (rst)
        ram_we |-> (cpu_in_ram || main_in_ram))
        else $error("ram_we outside the RAM region");

    // grant only once the request has been held through the sync
    grant_needs_request: assert property (@(posedge clk48) disable iff (rst)
        !main_busakn |-> !main_buse_n && $past(!main_buse_n))
        else $error("main_busakn low without a bus request");

endmodule

bind qsnd_sound qsnd_sva sva_i (.*);

// ==== tb_qsnd.sv ====
//////////////////////////////
// testbench for the sound board glue
// clock, reset, cen8, ROM and RAM models
// LFSR, compare tasks, directed tests
//////////////////////////////
`timescale 1ns/1ns

module tb_qsnd import qsnd_pkg::*; ();

    logic               clk48;
    logic               rst;
    logic               cen8 = 1'b0;
    cpu_bus_t           cpu;
    logic               cpu_busak_n;
    logic [7:0]         cpu_din;
    logic               cpu_busrq_n;
    logic               cpu_cen;
    logic               int_n;
    logic [23:1]        main_addr;
    logic [7:0]         main_dout;
    logic               main_ldswn;
    logic               main_buse_n;
    logic [7:0]         main_din;
    logic               main_busakn;
    logic [7:0]         rom_data;
    logic               rom_ok;
    logic [rom_aw-1:0]  rom_addr;
    logic               rom_cs;
    logic [7:0]         ram_q;
    logic [ram_aw-1:0]  ram_addr;
    logic               ram_we;
    logic [7:0]         ram_din;
    dsp_out_t           dsp;
    logic               dsp_rst;
    logic               dsp_irq;
    logic [15:0]        dsp_pbus_in;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic               sample;
    logic [qsnd_aw-1:0] qsnd_addr;

    logic [7:0]  ram [2**ram_aw];   // work RAM model
    logic [15:0] lfsr;
    logic [3:0]  bank_exp;          // bank last written
    int          cen_cnt = 0;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;

    qsnd_sound #(.int_period(64)) dut_i (.*);

    // program ROM contents as a function of the full address
    function automatic logic [7:0] rom_byte(input logic [rom_aw-1:0] a);
        return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]} ^ 8'h5a;
    endfunction

    assign rom_data = rom_byte(rom_addr);
    assign ram_q    = ram[ram_addr];

    always @(posedge clk48)
        if (ram_we)
            ram[ram_addr] <= ram_din;

    initial begin
        clk48 = 1'b0;
        forever #4 clk48 = ~clk48;
    end

    // cen8 high on every sixth clock
    always @(posedge clk48) begin
        #1;
        cen_cnt = (cen_cnt == 5) ? 0 : cen_cnt + 1;
        cen8    = (cen_cnt == 5);
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [qsnd_aw-1:0] got,
                              input logic [qsnd_aw-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_sample(input string name, input logic signed [15:0] got,
                                input logic signed [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        errors++;
        $display("timeout: %s did not happen in time", what);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark)
            $display("test %-10s ok", name);
        else
            $display("test %-10s failed with %0d errors", name, errors - err_mark);
    endtask

    task automatic step();
        @(posedge clk48);
        #1;
    endtask

    task automatic settle();
        @(negedge clk48);
    endtask

    // one sound CPU memory cycle, read data and ROM address taken after decode
    task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
                             input logic write, output logic [7:0] rdata,
                             output logic [qsnd_aw-1:0] raddr);
        cpu.addr   = addr;
        cpu.dout   = data;
        cpu.mreq_n = 1'b0;
        cpu.rd_n   = write;
        cpu.wr_n   = ~write;
        @(posedge clk48);
        @(negedge clk48);
        rdata = cpu_din;
        raddr = qsnd_aw'(rom_addr);
        step;
        cpu.mreq_n = 1'b1;
        cpu.rd_n   = 1'b1;
        cpu.wr_n   = 1'b1;
        step;   // let the register strobes finish
    endtask

    task automatic reset_values();
        logic [7:0]         d;
        logic [qsnd_aw-1:0] a;
        err_mark = errors;
        settle;
        check_bit("sample", sample, 1'b0);
        check_bit("dsp_irq", dsp_irq, 1'b0);
        check_bit("rom_cs", rom_cs, 1'b0);
        check_bit("ram_we", ram_we, 1'b0);
        check_bit("int_n", int_n, 1'b1);
        check_bit("main_busakn", main_busakn, 1'b1);
        check_bit("dsp_rst", dsp_rst, 1'b1);
        check_sample("left", left, 16'sd0);
        check_addr("qsnd_addr", qsnd_addr, '0);
        step;
        bus_cycle(16'hd007, 8'h00, 1'b0, d, a);
        check_byte("status", d, 8'hf0);     // ready, bank 0
        end_test("reset");
    endtask

    task automatic rom_mapping();
        logic [15:0]        r;
        logic [15:0]        addr;
        logic [7:0]         d;
        logic [qsnd_aw-1:0] a;
        logic [qsnd_aw-1:0] exp;
        err_mark = errors;
        rand_bits(15, r);
        addr = {1'b0, r[14:0]};
        bus_cycle(addr, 8'h00, 1'b0, d, a);
        check_addr("rom_addr", a, qsnd_aw'(addr));
        check_byte("cpu_din", d, rom_byte(rom_aw'(addr)));
        rand_bits(8, r);
        bank_exp = r[3:0];
        bus_cycle(16'hd003, r[7:0], 1'b1, d, a);
        rand_bits(14, r);
        addr = {2'b10, r[13:0]};
        bus_cycle(addr, 8'h00, 1'b0, d, a);
        exp = qsnd_aw'(32'h8000 + 32'(bank_exp) * 32'h4000 + 32'(r[13:0]));
        check_addr("rom_addr", a, exp);
        check_byte("cpu_din", d, rom_byte(rom_aw'(exp)));
        end_test("rom_map");
    endtask

    task automatic status_and_reset();
        logic [15:0]        r;
        logic [7:0]         b;
        logic [7:0]         d;
        logic [qsnd_aw-1:0] a;
        err_mark = errors;
        rand_bits(8, r);
        b        = r[7:0];
        bank_exp = b[3:0];
        bus_cycle(16'hd003, b, 1'b1, d, a);
        settle;
        check_bit("dsp_rst", dsp_rst, ~b[7]);
        step;
        bus_cycle(16'hd003, b ^ 8'h80, 1'b1, d, a);   // flip the reset bit only
        settle;
        check_bit("dsp_rst", dsp_rst, b[7]);
        step;
        bus_cycle(16'hd007, 8'h00, 1'b0, d, a);
        check_byte("status", d, {1'b1, 3'b111, bank_exp});
        bus_cycle(16'he000, 8'h00, 1'b0, d, a);
        check_byte("unmapped", d, 8'hff);
        end_test("status");
    endtask

    task automatic mailbox_transfer();
        logic [15:0]        r;
        logic [15:0]        word;
        logic [7:0]         abyte;
        logic [7:0]         d;
        logic [qsnd_aw-1:0] a;
        err_mark = errors;
        rand_bits(16, word);
        rand_bits(8, r);
        abyte = r[7:0];
        bus_cycle(16'hd000, word[15:8], 1'b1, d, a);
        bus_cycle(16'hd001, word[7:0], 1'b1, d, a);
        bus_cycle(16'hd002, abyte, 1'b1, d, a);
        settle;
        check_bit("dsp_irq", dsp_irq, 1'b1);
        check_word("dsp_pbus_in", dsp_pbus_in, {8'h00, abyte});
        step;
        bus_cycle(16'hd007, 8'h00, 1'b0, d, a);
        check_byte("status", d, {1'b0, 3'b111, bank_exp});  // busy while irq is up
        dsp.pids_n = 1'b0;
        step;
        dsp.pids_n = 1'b1;
        step;
        settle;
        check_bit("dsp_irq", dsp_irq, 1'b0);
        check_word("dsp_pbus_in", dsp_pbus_in, word);
        step;
        end_test("mailbox");
    endtask

    task automatic serial_word(input logic [15:0] w);
        dsp.ser_out = w;
        dsp.sadd    = 1'b1;
        step;
        dsp.sadd = 1'b0;    // word taken on this fall
        step;
        step;
    endtask

    task automatic audio_capture();
        logic [15:0] wl;
        logic [15:0] wr;
        logic [15:0] pv;
        logic [15:0] r;
        int          n;
        err_mark = errors;
        rand_bits(16, wl);
        rand_bits(16, wr);
        dsp.psel = 1'b0;
        serial_word(wl);
        dsp.psel = 1'b1;
        step;
        step;
        serial_word(wr);    // psel high, right channel
        dsp.psel = 1'b0;
        step;
        dsp.psel = 1'b1;
        n = 0;
        while (sample !== 1'b1 && n < 10) begin
            @(negedge clk48);
            n++;
        end
        if (sample !== 1'b1) begin
            note_timeout("sample pulse");
        end else begin
            check_sample("left", left, {wl[13:0], 2'b00});
            check_sample("right", right, {wr[13:0], 2'b00});
            @(negedge clk48);
            check_bit("sample", sample, 1'b0);
        end
        step;
        rand_bits(16, pv);
        rand_bits(7, r);
        dsp.pbus_out = pv;
        dsp.pods_n   = 1'b0;
        step;
        dsp.pods_n = 1'b1;
        step;
        dsp.ab      = {9'h100, r[6:0]};    // bit 15 set, page in 6:0
        dsp.cen_cko = 1'b1;
        step;
        dsp.cen_cko = 1'b0;
        dsp.ab      = '0;
        settle;
        check_addr("qsnd_addr", qsnd_addr, {r[6:0], pv});
        step;
        end_test("audio");
    endtask

    // fetch at 0x4000 and up, four cen8 ticks in the window
    task automatic fetch_wait_slot();
        logic [15:0] r;
        logic [7:0]  ticks;
        logic [7:0]  cens;
        err_mark = errors;
        rand_bits(14, r);
        cpu.addr = {2'b01, r[13:0]};
        cpu.m1_n = 1'b0;
        ticks    = '0;
        cens     = '0;
        repeat (24) begin
            @(negedge clk48);
            if (cen8)
                ticks++;
            if (cpu_cen)
                cens++;
        end
        step;
        cpu.m1_n = 1'b1;
        check_byte("cpu_cen ticks", cens, ticks - 8'd1);  // one tick swallowed
        step;
        end_test("wait");
    endtask

    task automatic ack_int();
        int n;
        cpu.m1_n   = 1'b0;
        cpu.iorq_n = 1'b0;
        n = 0;
        while (int_n !== 1'b1 && n < 20) begin
            @(negedge clk48);
            n++;
        end
        check_bit("int_n", int_n, 1'b1);
        step;
        cpu.m1_n   = 1'b1;
        cpu.iorq_n = 1'b1;
    endtask

    task automatic bus_and_interrupt();
        logic [15:0] r;
        int          n;
        int          ticks;
        err_mark = errors;
        main_buse_n = 1'b0;
        settle;
        check_bit("cpu_busrq_n", cpu_busrq_n, 1'b0);
        step;
        cpu_busak_n = 1'b0;
        n = 0;
        while (main_busakn !== 1'b0 && n < 100) begin
            @(negedge clk48);
            n++;
        end
        if (main_busakn !== 1'b0)
            note_timeout("bus grant");
        step;
        rand_bits(15, r);
        main_addr = {8'd0, r[14:0]};   // main CPU reads ROM
        step;
        step;
        settle;
        check_byte("main_din", main_din, rom_byte(rom_aw'(r[14:0])));
        step;
        rand_bits(8, r);
        main_addr  = 23'h00c000;
        main_dout  = r[7:0];
        main_ldswn = 1'b0;
        n = 0;
        while (ram_we !== 1'b1 && n < 20) begin
            @(negedge clk48);
            n++;
        end
        if (ram_we !== 1'b1)
            note_timeout("main CPU RAM write");
        check_addr("ram_addr", qsnd_aw'(ram_addr), '0);
        check_byte("ram_din", ram_din, r[7:0]);
        step;
        main_ldswn = 1'b1;
        step;
        check_byte("ram[0]", ram[0], r[7:0]);
        main_buse_n = 1'b1;
        cpu_busak_n = 1'b1;
        settle;
        check_bit("main_busakn", main_busakn, 1'b1);
        step;
        n = 0;
        while (int_n !== 1'b0 && n < 480) begin
            @(negedge clk48);
            n++;
        end
        if (int_n !== 1'b0)
            note_timeout("first interrupt");
        step;
        ack_int;
        n = 0;
        ticks = 0;
        while (int_n !== 1'b0 && n < 480) begin
            @(negedge clk48);
            if (cen8)
                ticks++;
            n++;
        end
        if (int_n !== 1'b0) begin
            note_timeout("periodic interrupt");
        end else if (ticks > 64) begin
            errors++;
            $display("interrupt came %0d cen8 ticks after the acknowledge", ticks);
        end
        step;
        ack_int;
        end_test("bus_int");
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        tests       = 0;
        lfsr        = 16'd79;
        bank_exp    = 4'd0;
        rst         = 1'b1;
        cpu         = '1;   // all strobes idle
        cpu.addr    = '0;
        cpu.dout    = '0;
        cpu_busak_n = 1'b1;
        main_addr   = '0;
        main_dout   = '0;
        main_ldswn  = 1'b1;
        main_buse_n = 1'b1;
        rom_ok      = 1'b1;
        dsp         = '0;
        dsp.pods_n  = 1'b1;
        dsp.pids_n  = 1'b1;
        for (int i = 0; i < 2**ram_aw; i++)
            ram[i] <= i[7:0] ^ {3'd0, i[12:8]};
        repeat (10) @(posedge clk48);
        #1;
        rst = 1'b0;
        reset_values;
        rom_mapping;
        status_and_reset;
        mailbox_transfer;
        audio_capture;
        fetch_wait_slot;
        bus_and_interrupt;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
qsnd_pkg.sv
qsnd_bus_decode.sv
qsnd_regs.sv
qsnd_buslock.sv
qsnd_cpu_timing.sv
qsnd_audio_latch.sv
qsnd_sound.sv
qsnd_sva.sv
tb_qsnd.sv

// ==== Makefile ====
TOP = tb_qsnd

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
